/* verilog.f */
hdl/tbu_pkg.sv
hdl/survivor_store.sv
hdl/traceback_engine.sv
hdl/lifo_reorder.sv
hdl/tbu_top.sv
test/tb_clock_gen.sv
test/tbu_asserts.sv
test/tbu_tb.sv

/* Makefile */
# Verilator build and run for the traceback unit

VERILATOR ?= verilator
TOP       ?= tbu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test FAILED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tbu_tb.sv */
`timescale 1ns/1ps

module tbu_tb;
  import tbu_pkg::*;

  localparam int          TB_LEN      = DEF_TRACEBACK_LEN;
  localparam int          DEC_LEN     = DEF_DECODE_LEN;
  localparam int          MAX_STAGES  = 320;
  localparam int          NUM_ROWS    = 6;
  localparam int          WAIT_LIMIT  = 8 * (TB_LEN + DEC_LEN);
  localparam int          QUIET_LIMIT = 4 * (TB_LEN + DEC_LEN) + 64;
  localparam logic [31:0] SEED        = 32'h9fcf5abb;

  typedef enum int {PAT_ZERO, PAT_SHIFT, PAT_RANDOM} pattern_t;
  typedef enum int {GAP_FIXED, GAP_RANDOM} gap_t;

  logic                    clk;
  logic                    sys_rst;
  logic                    rst_req;
  state_t [NUM_STATES-1:0] prev_states;
  logic [NUM_STATES-1:0]   decisions;
  logic                    valid_in;
  logic                    vit_desc;
  state_t                  last_state;
  logic                    valid_out;

  string    row_name    [NUM_ROWS];
  pattern_t row_pattern [NUM_ROWS];
  int       row_stages  [NUM_ROWS];
  gap_t     row_gap     [NUM_ROWS];
  int       row_blocks  [NUM_ROWS];   // Expected number of decoded blocks

  state_t   stage_prev  [MAX_STAGES][NUM_STATES];  // Copy of every stage sent
  logic     stage_dec   [MAX_STAGES][NUM_STATES];
  logic     exp_bits    [$];
  state_t   exp_states  [$];
  int       data_seed;
  int       gap_seed;

  tb_clock_gen #(
    .period_ns (8.0),
    .rst_cycles(3)
  ) i_clk_gen (
    .rst_req(rst_req),
    .clk    (clk),
    .sys_rst(sys_rst)
  );

  tbu_top #(
    .traceback_len(TB_LEN),
    .decode_len   (DEC_LEN)
  ) i_dut (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .prev_states(prev_states),
    .decisions  (decisions),
    .valid_in   (valid_in),
    .vit_desc   (vit_desc),
    .last_state (last_state),
    .valid_out  (valid_out)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input int expected, input int actual);
    if (expected != actual) begin
      abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic set_row(input int idx, input string name, input pattern_t pat,
                         input int n, input gap_t gap, input int blocks);
    row_name[idx]    = name;
    row_pattern[idx] = pat;
    row_stages[idx]  = n;
    row_gap[idx]     = gap;
    row_blocks[idx]  = blocks;
  endtask

  task automatic load_table();
    set_row(0, "short_run",     PAT_RANDOM, 50,  GAP_FIXED,  0);  // Below the first trigger
    set_row(1, "zero_path",     PAT_ZERO,   120, GAP_FIXED,  3);
    set_row(2, "shift_trellis", PAT_SHIFT,  100, GAP_FIXED,  2);
    set_row(3, "exact_first",   PAT_SHIFT,  56,  GAP_RANDOM, 1);
    set_row(4, "random_fixed",  PAT_RANDOM, 300, GAP_FIXED,  8);
    set_row(5, "random_gaps",   PAT_RANDOM, 300, GAP_RANDOM, 8);  // Same data as row 4
  endtask

  task automatic make_stages(input pattern_t pat, input int n);
    logic [31:0] rnd;
    state_t      s_idx;
    data_seed = SEED;                            // Same stage data for equal patterns
    for (int k = 0; k < n; k++) begin
      rnd = $random(data_seed);                  // Per-stage top bit of the shift trellis
      for (int s = 0; s < NUM_STATES; s++) begin
        s_idx = state_t'(s);
        case (pat)
          PAT_SHIFT: begin
            stage_prev[k][s] = {rnd[0], s_idx[STATE_W-1:1]};
            stage_dec[k][s]  = s_idx[0];
          end
          PAT_RANDOM: begin
            rnd              = $random(data_seed);
            stage_prev[k][s] = rnd[STATE_W-1:0];
            stage_dec[k][s]  = rnd[8];
          end
          default: begin
            stage_prev[k][s] = '0;
            stage_dec[k][s]  = 1'b0;
          end
        endcase
      end
    end
  endtask

  task automatic build_expected(input int n_blocks);
    state_t row;
    int     newest;
    int     stage;
    logic   blk_bit   [DEC_LEN];
    state_t blk_state [DEC_LEN];
    exp_bits.delete();
    exp_states.delete();
    for (int b = 0; b < n_blocks; b++) begin
      newest = TB_LEN + DEC_LEN * (b + 1) - 1;   // Stage that triggers block b
      row    = '0;
      for (int j = 0; j < TB_LEN + DEC_LEN; j++) begin
        stage = newest - j;
        if (j >= TB_LEN) begin
          blk_bit[j - TB_LEN]   = stage_dec[stage][row];
          blk_state[j - TB_LEN] = row;
        end
        row = stage_prev[stage][row];
      end
      // Walk is newest first, output is oldest first
      for (int i = DEC_LEN - 1; i >= 0; i--) begin
        exp_bits.push_back(blk_bit[i]);
        exp_states.push_back(blk_state[i]);
      end
    end
  endtask

  task automatic apply_reset();
    int waited;
    @(posedge clk);
    rst_req  <= 1'b1;
    valid_in <= 1'b0;
    @(posedge clk);
    rst_req <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (sys_rst) begin
      if (waited == 10) begin
        abort_run("Reset did not release within 10 cycles");
      end
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic drive_stages(input int n, input gap_t gap);
    state_t [NUM_STATES-1:0] col_prev;
    logic [NUM_STATES-1:0]   col_dec;
    logic [31:0]             rnd;
    int                      period;
    for (int k = 0; k < n; k++) begin
      for (int s = 0; s < NUM_STATES; s++) begin
        col_prev[s] = stage_prev[k][s];
        col_dec[s]  = stage_dec[k][s];
      end
      period = 2;                                // Cycles from one strobe to the next
      if (gap == GAP_RANDOM) begin
        rnd    = $random(gap_seed);
        period = 2 + int'(rnd % 3);
      end
      @(posedge clk);
      prev_states <= col_prev;
      decisions   <= col_dec;
      valid_in    <= 1'b1;
      @(posedge clk);
      valid_in <= 1'b0;
      repeat (period - 2) @(posedge clk);
    end
  endtask

  task automatic collect_blocks(input string name, input int n_blocks);
    int idx;
    int waited;
    idx = 0;
    for (int b = 0; b < n_blocks; b++) begin
      waited = 0;
      while (!valid_out) begin
        if (waited == WAIT_LIMIT) begin
          abort_run($sformatf("Timeout in %s, block %0d never showed on valid_out", name, b));
        end
        @(negedge clk);
        waited++;
      end
      for (int i = 0; i < DEC_LEN; i++) begin
        check($sformatf("%s valid_out b%0d i%0d", name, b, i), 1, int'(valid_out));
        check($sformatf("%s vit_desc b%0d i%0d", name, b, i),
              int'(exp_bits[idx]), int'(vit_desc));
        check($sformatf("%s last_state b%0d i%0d", name, b, i),
              int'(exp_states[idx]), int'(last_state));
        idx++;
        @(negedge clk);
      end
      check($sformatf("%s burst end b%0d", name, b), 0, int'(valid_out));
    end
  endtask

  task automatic check_quiet(input string name);
    for (int c = 0; c < QUIET_LIMIT; c++) begin
      @(negedge clk);
      check($sformatf("%s extra valid_out c%0d", name, c), 0, int'(valid_out));
    end
  endtask

  initial begin
    valid_in    = 1'b0;
    prev_states = '0;
    decisions   = '0;
    rst_req     = 1'b0;
    gap_seed    = SEED;
    load_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      make_stages(row_pattern[r], row_stages[r]);
      build_expected(row_blocks[r]);
      apply_reset();
      fork
        drive_stages(row_stages[r], row_gap[r]);
        collect_blocks(row_name[r], row_blocks[r]);
      join
      check_quiet(row_name[r]);                  // No block beyond the expected count
    end
    $display("Test OK");
    $finish;
  end

endmodule

/* test/tbu_asserts.sv */
`timescale 1ns/1ps

module tbu_asserts #(
  parameter int decode_len = tbu_pkg::DEF_DECODE_LEN
) (
  input logic clk,
  input logic sys_rst,
  input logic valid_in,
  input logic valid_out
);
  int burst_len;   // valid_out cycles seen in the current burst

  always_ff @(posedge clk) begin
    if (sys_rst || !valid_out) begin
      burst_len <= 0;
    end else begin
      burst_len <= burst_len + 1;
    end
  end

  strobe_spacing: assert property (@(posedge clk) disable iff (sys_rst)
    valid_in |=> !valid_in)
    else $error("valid_in high on two consecutive cycles");

  quiet_after_reset: assert property (@(posedge clk) sys_rst |=> !valid_out)
    else $error("valid_out high in the cycle after reset");

  // Burst may not run past decode_len
  burst_not_long: assert property (@(posedge clk) disable iff (sys_rst)
    valid_out |-> (burst_len < decode_len))
    else $error("valid_out burst longer than decode_len");

  burst_not_short: assert property (@(posedge clk) disable iff (sys_rst)
    $fell(valid_out) |-> (burst_len == decode_len))
    else $error("valid_out burst shorter than decode_len");

endmodule

bind tbu_top tbu_asserts #(
  .decode_len(decode_len)
) i_asserts (
  .clk      (clk),
  .sys_rst  (sys_rst),
  .valid_in (valid_in),
  .valid_out(valid_out)
);

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real period_ns  = 8.0,
  parameter int  rst_cycles = 3
) (
  input  logic rst_req,    // Restart the reset sequence
  output logic clk,
  output logic sys_rst
);
  logic clk_q   = 1'b0;
  logic rst_q   = 1'b1;
  int   rst_cnt = rst_cycles;  // Rising edges left in reset

  assign clk     = clk_q;
  assign sys_rst = rst_q;

  initial begin
    forever #(period_ns / 2.0) clk_q = ~clk_q;
  end

  always @(posedge clk_q) begin
    if (rst_req) begin
      rst_q   <= 1'b1;
      rst_cnt <= rst_cycles;
    end else if (rst_cnt > 0) begin
      rst_q   <= (rst_cnt > 1);     // Drop after the last counted edge
      rst_cnt <= rst_cnt - 1;
    end
  end

endmodule

/* hdl/tbu_top.sv */
`timescale 1ns/1ps

module tbu_top #(
  parameter int traceback_len = tbu_pkg::DEF_TRACEBACK_LEN,
  parameter int decode_len    = tbu_pkg::DEF_DECODE_LEN
) (
  input  logic                                      clk,
  input  logic                                      sys_rst,
  input  tbu_pkg::state_t [tbu_pkg::NUM_STATES-1:0] prev_states,
  input  logic [tbu_pkg::NUM_STATES-1:0]            decisions,
  input  logic                                      valid_in,  // At most every other cycle
  output logic                                      vit_desc,
  output tbu_pkg::state_t                           last_state,
  output logic                                      valid_out
);
  import tbu_pkg::*;

  // Store to engine
  logic        block_start;
  stage_addr_t newest_addr;
  stage_addr_t rd_addr;
  column_t     rd_column;

  // Engine to reorder buffer
  logic        dec_valid;
  logic        dec_bit;
  state_t      dec_state;
  logic        dec_last;

  survivor_store #(
    .traceback_len(traceback_len),
    .decode_len   (decode_len)
  ) i_store (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .valid_in   (valid_in),
    .prev_states(prev_states),
    .decisions  (decisions),
    .rd_addr    (rd_addr),
    .rd_column  (rd_column),
    .newest_addr(newest_addr),
    .block_start(block_start)
  );

  traceback_engine #(
    .traceback_len(traceback_len),
    .decode_len   (decode_len)
  ) i_engine (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .block_start(block_start),
    .newest_addr(newest_addr),
    .rd_column  (rd_column),
    .rd_addr    (rd_addr),
    .dec_valid  (dec_valid),
    .dec_bit    (dec_bit),
    .dec_state  (dec_state),
    .dec_last   (dec_last)
  );

  lifo_reorder #(
    .decode_len(decode_len)
  ) i_reorder (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .dec_valid (dec_valid),
    .dec_bit   (dec_bit),
    .dec_state (dec_state),
    .dec_last  (dec_last),
    .vit_desc  (vit_desc),
    .last_state(last_state),
    .valid_out (valid_out)
  );

endmodule

/* hdl/lifo_reorder.sv */
`timescale 1ns/1ps

module lifo_reorder #(
  parameter int decode_len = tbu_pkg::DEF_DECODE_LEN
) (
  input  logic            clk,
  input  logic            sys_rst,
  input  logic            dec_valid,
  input  logic            dec_bit,
  input  tbu_pkg::state_t dec_state,
  input  logic            dec_last,
  output logic            vit_desc,
  output tbu_pkg::state_t last_state,
  output logic            valid_out
);
  import tbu_pkg::*;

  localparam int IDX_W = (decode_len > 1) ? $clog2(decode_len) : 1;

  entry_t           bank_mem [2][decode_len];
  logic             fill_bank;     // Bank taking traceback output
  logic             drain_bank;    // Bank being played out
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  entry_t           rd_entry;

  // Oldest stage sits at the top of a filled bank
  assign rd_entry   = bank_mem[drain_bank][rd_idx];
  assign vit_desc   = rd_entry[ENTRY_W-1];
  assign last_state = rd_entry[STATE_W-1:0];

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      bank_mem[fill_bank][wr_idx] <= {dec_bit, dec_state};
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      fill_bank  <= 1'b0;
      drain_bank <= 1'b0;
      wr_idx     <= '0;
      rd_idx     <= '0;
      valid_out  <= 1'b0;
    end else begin
      // Drain side counts down to slot 0
      if (valid_out) begin
        if (rd_idx == '0) begin
          valid_out <= 1'b0;
        end else begin
          rd_idx <= rd_idx - 1'b1;
        end
      end

      // The last item of a block on the fill side swaps the banks
      if (dec_valid) begin
        if (dec_last) begin
          wr_idx     <= '0;
          fill_bank  <= ~fill_bank;
          drain_bank <= fill_bank;
          rd_idx     <= IDX_W'(decode_len - 1);
          valid_out  <= 1'b1;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/traceback_engine.sv */
`timescale 1ns/1ps

module traceback_engine #(
  parameter int traceback_len = tbu_pkg::DEF_TRACEBACK_LEN,
  parameter int decode_len    = tbu_pkg::DEF_DECODE_LEN
) (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  logic                 block_start,
  input  tbu_pkg::stage_addr_t newest_addr,
  input  tbu_pkg::column_t     rd_column,
  output tbu_pkg::stage_addr_t rd_addr,
  output logic                 dec_valid,
  output logic                 dec_bit,
  output tbu_pkg::state_t      dec_state,
  output logic                 dec_last
);
  import tbu_pkg::*;

  localparam int TOTAL_STEPS = traceback_len + decode_len;
  localparam int STEP_W      = $clog2(TOTAL_STEPS);

  typedef enum logic [1:0] {
    TB_IDLE,    // Waiting for block_start
    TB_PRIME,   // First read in flight
    TB_TRACE    // One stage per clock
  } tb_state_t;

  tb_state_t         tb_state;
  state_t            row;          // State being followed back
  logic [STEP_W-1:0] step_cnt;
  entry_t            cur_entry;
  logic              emit_step;
  logic              final_step;
  stage_addr_t       prev_addr;

  // rd_column always belongs to the address issued one cycle earlier,
  // so the current row picks its own entry straight out of it
  always_comb begin
    cur_entry  = rd_column[row*ENTRY_W +: ENTRY_W];
    emit_step  = (step_cnt >= STEP_W'(traceback_len));       // Past the merge depth
    final_step = (step_cnt == STEP_W'(TOTAL_STEPS - 1));
    prev_addr  = (rd_addr == '0) ? stage_addr_t'(MEM_DEPTH - 1) : rd_addr - 1'b1;
  end

  // Control path
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      tb_state  <= TB_IDLE;
      step_cnt  <= '0;
      rd_addr   <= '0;
      dec_valid <= 1'b0;
      dec_last  <= 1'b0;
    end else begin
      dec_valid <= 1'b0;
      dec_last  <= 1'b0;
      case (tb_state)
        TB_IDLE: begin
          if (block_start) begin
            rd_addr  <= newest_addr;            // Start at the newest stage
            step_cnt <= '0;
            tb_state <= TB_PRIME;
          end
        end

        TB_PRIME: begin
          rd_addr  <= prev_addr;                // Keep one read ahead of the walk
          tb_state <= TB_TRACE;
        end

        TB_TRACE: begin
          rd_addr   <= prev_addr;
          step_cnt  <= step_cnt + 1'b1;
          dec_valid <= emit_step;
          dec_last  <= final_step;
          if (final_step) begin
            tb_state <= TB_IDLE;
          end
        end

        default: begin
          tb_state <= TB_IDLE;
        end
      endcase
    end
  end

  // Path state and decoded payload
  always_ff @(posedge clk) begin
    if (tb_state == TB_PRIME) begin
      row <= '0;                                // Every traceback starts in state 0
    end else if (tb_state == TB_TRACE) begin
      row       <= cur_entry[STATE_W-1:0];      // Follow the survivor back
      dec_bit   <= cur_entry[ENTRY_W-1];
      dec_state <= row;
    end
  end

endmodule

/* hdl/survivor_store.sv */
`timescale 1ns/1ps

module survivor_store #(
  parameter int traceback_len = tbu_pkg::DEF_TRACEBACK_LEN,
  parameter int decode_len    = tbu_pkg::DEF_DECODE_LEN
) (
  input  logic                                      clk,
  input  logic                                      sys_rst,
  input  logic                                      valid_in,
  input  tbu_pkg::state_t [tbu_pkg::NUM_STATES-1:0] prev_states,
  input  logic [tbu_pkg::NUM_STATES-1:0]            decisions,
  input  tbu_pkg::stage_addr_t                      rd_addr,
  output tbu_pkg::column_t                          rd_column,
  output tbu_pkg::stage_addr_t                      newest_addr,
  output logic                                      block_start
);
  import tbu_pkg::*;

  localparam int FIRST_BLOCK = traceback_len + decode_len;
  localparam int CNT_W       = $clog2(FIRST_BLOCK + 1);

  column_t          surv_mem [MEM_DEPTH];
  column_t          wr_column;
  stage_addr_t      wr_addr;
  logic [CNT_W-1:0] stage_cnt;     // Stages since the last trigger
  logic [CNT_W-1:0] trigger_cnt;
  logic             first_done;    // First full block has been triggered
  logic             trigger;

  // Pack the incoming stage so slot s holds {decision, prev_state} of state s
  always_comb begin
    for (int s = 0; s < NUM_STATES; s++) begin
      wr_column[s*ENTRY_W +: ENTRY_W] = {decisions[s], prev_states[s]};
    end
  end

  // Merge depth is only needed before the very first block
  assign trigger_cnt = first_done ? CNT_W'(decode_len) : CNT_W'(FIRST_BLOCK);
  assign trigger     = valid_in && ((stage_cnt + 1'b1) == trigger_cnt);

  // Single write port, registered read port
  always_ff @(posedge clk) begin
    if (valid_in) begin
      surv_mem[wr_addr] <= wr_column;
    end
    rd_column <= surv_mem[rd_addr];
  end

  // Address of the stage just written goes out with block_start
  always_ff @(posedge clk) begin
    if (valid_in) begin
      newest_addr <= wr_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_addr     <= '0;
      stage_cnt   <= '0;
      first_done  <= 1'b0;
      block_start <= 1'b0;
    end else begin
      block_start <= trigger;                     // One cycle after the write edge
      if (valid_in) begin
        wr_addr <= (wr_addr == stage_addr_t'(MEM_DEPTH - 1)) ? '0 : wr_addr + 1'b1;
        if (trigger) begin
          stage_cnt  <= '0;
          first_done <= 1'b1;
        end else begin
          stage_cnt <= stage_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/tbu_pkg.sv */
package tbu_pkg;

  // Trellis geometry
  localparam int NUM_STATES = 64;
  localparam int STATE_W    = 6;                 // log2 of NUM_STATES
  localparam int ENTRY_W    = STATE_W + 1;       // Decision bit above previous state

  // Survivor memory holds this many trellis stages
  localparam int MEM_DEPTH  = 128;

  // Defaults for the traceback and decode lengths
  // Legal pairs need traceback + 4 <= decode and traceback + 2 * decode <= 96
  localparam int DEF_TRACEBACK_LEN = 24;
  localparam int DEF_DECODE_LEN    = 32;

  // One state index
  typedef logic [STATE_W-1:0] state_t;

  // One survivor entry packed as {decision, prev_state}
  typedef logic [ENTRY_W-1:0] entry_t;

  // A whole stage with the entry for state s at bits [s*ENTRY_W +: ENTRY_W]
  typedef logic [NUM_STATES*ENTRY_W-1:0] column_t;

  // Survivor memory address
  typedef logic [$clog2(MEM_DEPTH)-1:0] stage_addr_t;

endpackage
